/* project.f */
src/wb_pkg.sv
src/wb_rr_arbiter.sv
src/wb_decode_err_slave.sv
src/wb_interconnect_2x1.sv
src/wb_sram_slave.sv
src/wb_subsys_top.sv
sim/tb_wb_subsys.sv

/* sim/tb_wb_subsys.sv */
`timescale 1ns/1ns

module tb_wb_subsys
	import wb_pkg::*;
();

	localparam int TIMEOUT_CYC = 50;
	localparam int XFER_LAT = 3;

	logic    clk;
	logic    rstn;
	wb_req_t m_req [N_MASTERS];
	wb_rsp_t m_rsp [N_MASTERS];
	logic [N_MASTERS-1:0] done;

	// Expected response per master, set when its transfer starts
	logic                 exp_err [N_MASTERS];
	logic                 exp_chk [N_MASTERS];
	logic [WB_DATA_W-1:0] exp_dat [N_MASTERS];

	// Reference copy of the memory
	logic [WB_DATA_W-1:0] ref_mem [SRAM_DEPTH];

	logic       lat_chk;
	logic [7:0] lat_cnt;
	logic       fair_chk;
	int         fair_cnt;
	logic       last_done;

	int err_cnt;
	int err_mark;
	int tests_run;
	int tests_passed;
	int xfer_cnt;

	wb_subsys_top wb_subsys_top_inst (
		.clk      (clk),
		.rstn     (rstn),
		.m0_req_i (m_req[0]),
		.m0_rsp_o (m_rsp[0]),
		.m1_req_i (m_req[1]),
		.m1_rsp_o (m_rsp[1])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycles from the first edge that sees m0 stb up to its response
	always @(posedge clk) begin
		if (!rstn || !m_req[0].stb || done[0]) begin
			lat_cnt <= '0;
		end else begin
			lat_cnt <= lat_cnt + 1'b1;
		end
	end

	// Which master completed last while both compete
	always @(posedge clk) begin
		if (!rstn || !fair_chk) begin
			fair_cnt <= 0;
			last_done <= 1'b0;
		end else if (|done) begin
			fair_cnt <= fair_cnt + 1;
			last_done <= done[1];
		end
	end

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_chk
		assign done[m] = m_rsp[m].ack || m_rsp[m].err;

		a_err_val: assert property (@(posedge clk) disable iff (!rstn)
			done[m] |-> (m_rsp[m].err == exp_err[m]))
		else begin
			$display("** Error at %0t: m%0d_rsp_o.err expected %0b got %0b",
				$time, m, $sampled(exp_err[m]), $sampled(m_rsp[m].err));
			err_cnt = err_cnt + 1;
		end

		a_ack_val: assert property (@(posedge clk) disable iff (!rstn)
			done[m] |-> (m_rsp[m].ack == !exp_err[m]))
		else begin
			$display("** Error at %0t: m%0d_rsp_o.ack expected %0b got %0b",
				$time, m, !$sampled(exp_err[m]), $sampled(m_rsp[m].ack));
			err_cnt = err_cnt + 1;
		end

		a_dat_val: assert property (@(posedge clk) disable iff (!rstn)
			(done[m] && exp_chk[m]) |-> (m_rsp[m].dat_r == exp_dat[m]))
		else begin
			$display("** Error at %0t: m%0d_rsp_o.dat_r expected %08h got %08h",
				$time, m, $sampled(exp_dat[m]), $sampled(m_rsp[m].dat_r));
			err_cnt = err_cnt + 1;
		end

		// No response may reach a master that is not strobing
		a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
			!m_req[m].stb |-> !done[m])
		else begin
			$display("** Error at %0t: m%0d_rsp_o ack|err expected 0 got %0b",
				$time, m, $sampled(done[m]));
			err_cnt = err_cnt + 1;
		end
	end

	a_latency: assert property (@(posedge clk) disable iff (!rstn)
		(lat_chk && done[0]) |-> (lat_cnt == XFER_LAT))
	else begin
		$display("** Error at %0t: lat_cnt expected %0d got %0d",
			$time, XFER_LAT, $sampled(lat_cnt));
		err_cnt = err_cnt + 1;
	end

	// After the first completion the masters take turns
	a_fair: assert property (@(posedge clk) disable iff (!rstn)
		(fair_chk && fair_cnt != 0 && |done) |-> (done[1] != last_done))
	else begin
		$display("** Error at %0t: done_id expected %0d got %0d",
			$time, !$sampled(last_done), $sampled(done[1]));
		err_cnt = err_cnt + 1;
	end

	function automatic logic [WB_DATA_W-1:0] fill_word(input logic [WB_ADDR_W-1:0] adr);
		return (adr * 32'h9E37_79B1) ^ {adr[15:0], ~adr[15:0]};
	endfunction

	task automatic print_summary();
		$display("summary: %0d tests run, %0d passed, %0d transfers, %0d failed checks",
			tests_run, tests_passed, xfer_cnt, err_cnt);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		print_summary();
		$display("Test FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt == err_mark) begin
			tests_passed++;
		end
		$display("test %0d %s: %0d errors", tests_run, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	// One classic cycle, starts and ends 2 ns after a rising edge
	task automatic do_xfer(input int m, input logic [WB_ADDR_W-1:0] addr, input logic wr,
		input logic [WB_SEL_W-1:0] bsel, input logic [WB_DATA_W-1:0] wdata);
		logic                  in_win;
		logic                  got;
		int                    cycles;
		logic [SRAM_IDX_W-1:0] idx;
		in_win = (addr - SRAM_BASE) <= (SRAM_LIMIT - SRAM_BASE);
		idx = addr[SRAM_IDX_W+1:2];
		exp_err[m] = !in_win;
		exp_chk[m] = !in_win || !wr;
		exp_dat[m] = in_win ? ref_mem[idx] : '0;
		m_req[m] = '{adr: addr, dat_w: wdata, sel: bsel, we: wr, cyc: 1'b1, stb: 1'b1};
		got = 1'b0;
		cycles = 0;
		while (!got && cycles < TIMEOUT_CYC) begin
			@(negedge clk);
			got = done[m];
			cycles++;
		end
		if (!got) begin
			abort_run($sformatf("timeout: master %0d got no ack or err for address %08h",
				m, addr));
		end
		@(posedge clk);
		#2;
		if (wr && in_win) begin
			for (int b = 0; b < WB_SEL_W; b++) begin
				if (bsel[b]) begin
					ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
				end
			end
		end
		m_req[m] = '0;
		xfer_cnt++;
	endtask

	task automatic test_reset_latency();
		wait_cycles(3);
		lat_chk = 1'b1;
		do_xfer(0, 32'h0000_0000, 1'b1, 4'hF, fill_word(32'h0000_0000));
		lat_chk = 1'b0;
		wait_cycles(2);
		end_test("reset and latency");
	endtask

	// m0 fills even words and m1 odd words, then each reads the other's
	task automatic test_cross_rw();
		logic [WB_ADDR_W-1:0] adr;
		for (int i = 0; i < SRAM_DEPTH; i++) begin
			adr = SRAM_BASE + 4 * i;
			do_xfer(i % 2, adr, 1'b1, 4'hF, fill_word(adr));
		end
		for (int i = 0; i < SRAM_DEPTH; i++) begin
			adr = SRAM_BASE + 4 * i;
			do_xfer(1 - (i % 2), adr, 1'b0, 4'hF, '0);
		end
		end_test("write and read back across masters");
	endtask

	task automatic test_byte_sel();
		do_xfer(0, 32'h0000_0040, 1'b1, 4'hF, 32'h1122_3344);
		do_xfer(1, 32'h0000_0040, 1'b1, 4'b0101, 32'hAABB_CCDD);
		do_xfer(0, 32'h0000_0040, 1'b0, 4'hF, '0);
		do_xfer(1, 32'h0000_0044, 1'b0, 4'hF, '0);
		end_test("byte selects");
	endtask

	task automatic test_decode_fail();
		// 0x410 would alias word 4 if the decode were wrong
		do_xfer(0, 32'h0000_0410, 1'b1, 4'hF, 32'hDEAD_BEEF);
		do_xfer(1, 32'h0001_0008, 1'b0, 4'hF, '0);
		do_xfer(1, 32'hFFFF_FFFC, 1'b1, 4'hF, 32'h0BAD_F00D);
		do_xfer(0, 32'h0000_0010, 1'b0, 4'hF, '0);
		do_xfer(1, 32'h0000_0008, 1'b0, 4'hF, '0);
		do_xfer(0, 32'h0000_03FC, 1'b0, 4'hF, '0);
		end_test("decode fail");
	endtask

	// Four writes then four reads inside a region of its own
	task automatic run_burst(input int m, input logic [WB_ADDR_W-1:0] base);
		logic [WB_ADDR_W-1:0] adr;
		for (int i = 0; i < 4; i++) begin
			adr = base + 4 * i;
			do_xfer(m, adr, 1'b1, 4'hF, ~fill_word(adr));
		end
		for (int i = 0; i < 4; i++) begin
			adr = base + 4 * i;
			do_xfer(m, adr, 1'b0, 4'hF, '0);
		end
	endtask

	task automatic test_contention();
		fair_chk = 1'b1;
		fork
			run_burst(0, 32'h0000_0100);
			run_burst(1, 32'h0000_0200);
		join
		fair_chk = 1'b0;
		wait_cycles(2);
		end_test("contention and fairness");
	endtask

	task automatic test_random(input int n);
		int                   m;
		logic [WB_ADDR_W-1:0] adr;
		logic                 wr;
		logic [WB_SEL_W-1:0]  bsel;
		logic [WB_DATA_W-1:0] wdata;
		for (int i = 0; i < n; i++) begin
			m = $urandom % N_MASTERS;
			if ($urandom % 4 == 0) begin
				adr = $urandom | 32'h0000_0400;
			end else begin
				adr = SRAM_BASE + ($urandom % 1024);
			end
			adr[1:0] = 2'b00;
			wr = $urandom % 2;
			bsel = $urandom;
			wdata = $urandom;
			do_xfer(m, adr, wr, bsel, wdata);
		end
		end_test("random traffic");
	endtask

	initial begin
		void'($urandom(32'h2977329f));
		rstn = 1'b0;
		m_req[0] = '0;
		m_req[1] = '0;
		for (int m = 0; m < N_MASTERS; m++) begin
			exp_err[m] = 1'b0;
			exp_chk[m] = 1'b0;
			exp_dat[m] = '0;
		end
		lat_chk = 1'b0;
		fair_chk = 1'b0;
		err_cnt = 0;
		err_mark = 0;
		tests_run = 0;
		tests_passed = 0;
		xfer_cnt = 0;
		repeat (2) @(posedge clk);
		#2;
		rstn = 1'b1;

		test_reset_latency();
		test_cross_rw();
		test_byte_sel();
		test_decode_fail();
		test_contention();
		test_random(200);

		print_summary();
		if (err_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* src/wb_decode_err_slave.sv */
`timescale 1ns/1ns

module wb_decode_err_slave
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic strobe;
	logic err_q;

	// A new transfer is one not already being answered
	assign strobe = req_i.cyc && req_i.stb && !err_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= strobe;
		end
	end

	// No data and never an ack from this target
	always_comb begin
		rsp_o.dat_r = '0;
		rsp_o.ack = 1'b0;
		rsp_o.err = err_q;
	end

	// The strobe that caused err is still held while err is shown
	a_err_after_stb: assert property (@(posedge clk) disable iff (!rstn)
		err_q |-> (req_i.cyc && req_i.stb));

endmodule

/* src/wb_interconnect_2x1.sv */
`timescale 1ns/1ns

module wb_interconnect_2x1
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t m0_req_i,
	output wb_rsp_t m0_rsp_o,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m1_rsp_o,
	output wb_req_t sram_req_o,
	input  wb_rsp_t sram_rsp_i
);

	wb_req_t m_req [N_MASTERS];
	wb_rsp_t m_rsp [N_MASTERS];
	wb_req_t t_req [N_TARGETS];
	wb_rsp_t t_rsp [N_TARGETS];

	// Per-master transfer state
	logic             pending [N_MASTERS];
	logic [TGT_W-1:0] tgt_sel [N_MASTERS];
	logic             owns    [N_MASTERS];

	// Per-target arbitration
	logic [N_MASTERS-1:0] tgt_req    [N_TARGETS];
	logic                 tgt_gnt    [N_TARGETS];
	logic [MID_W-1:0]     tgt_gnt_id [N_TARGETS];

	function automatic logic [TGT_W-1:0] addr_to_tgt(input logic [WB_ADDR_W-1:0] adr);
		if (adr >= SRAM_BASE && adr <= SRAM_LIMIT) begin
			return TGT_SRAM;
		end
		return TGT_ERR;
	endfunction

	assign m_req[0] = m0_req_i;
	assign m_req[1] = m1_req_i;
	assign m0_rsp_o = m_rsp[0];
	assign m1_rsp_o = m_rsp[1];

	assign sram_req_o = t_req[TGT_SRAM];
	assign t_rsp[TGT_SRAM] = sram_rsp_i;

	// Latch the decoded target when a master starts a transfer
	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				pending[m] <= 1'b0;
				tgt_sel[m] <= TGT_SRAM;
			end
		end else begin
			for (int m = 0; m < N_MASTERS; m++) begin
				if (!pending[m]) begin
					if (m_req[m].cyc && m_req[m].stb) begin
						pending[m] <= 1'b1;
						tgt_sel[m] <= addr_to_tgt(m_req[m].adr);
					end
				end else if (m_rsp[m].ack || m_rsp[m].err) begin
					pending[m] <= 1'b0;
				end
			end
		end
	end

	// Request vector seen by each target's arbiter
	always_comb begin
		for (int t = 0; t < N_TARGETS; t++) begin
			for (int m = 0; m < N_MASTERS; m++) begin
				tgt_req[t][m] = pending[m] && (tgt_sel[m] == TGT_W'(t));
			end
		end
	end

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_arb
		wb_rr_arbiter arb_inst (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (tgt_req[t]),
			.gnt_o    (tgt_gnt[t]),
			.gnt_id_o (tgt_gnt_id[t])
		);
	end

	// A master owns its target only while pending and holding that target's grant
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			owns[m] = pending[m] && tgt_gnt[tgt_sel[m]] &&
				(tgt_gnt_id[tgt_sel[m]] == MID_W'(m));
		end
	end

	// Request mux toward each target
	always_comb begin
		for (int t = 0; t < N_TARGETS; t++) begin
			if (tgt_gnt[t] && owns[tgt_gnt_id[t]] &&
				(tgt_sel[tgt_gnt_id[t]] == TGT_W'(t))) begin
				t_req[t] = m_req[tgt_gnt_id[t]];
			end else begin
				t_req[t] = '0;
			end
		end
	end

	// Response goes back to the owning master only
	always_comb begin
		for (int m = 0; m < N_MASTERS; m++) begin
			if (owns[m]) begin
				m_rsp[m] = t_rsp[tgt_sel[m]];
			end else begin
				m_rsp[m] = '0;
			end
		end
	end

	// Unmapped addresses end here
	wb_decode_err_slave err_slave_inst (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (t_req[TGT_ERR]),
		.rsp_o (t_rsp[TGT_ERR])
	);

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_chk
		a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
			!(m_rsp[m].ack && m_rsp[m].err));
	end

endmodule

/* src/wb_pkg.sv */
package wb_pkg;

	// Bus widths
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;
	localparam int WB_SEL_W = WB_DATA_W / 8;

	// Memory window, byte addressed
	localparam logic [WB_ADDR_W-1:0] SRAM_BASE = 32'h0000_0000;
	localparam logic [WB_ADDR_W-1:0] SRAM_LIMIT = 32'h0000_03FF;
	localparam int SRAM_DEPTH = 256;
	localparam int SRAM_IDX_W = $clog2(SRAM_DEPTH);

	// Masters and targets on the interconnect
	localparam int N_MASTERS = 2;
	localparam int N_TARGETS = 2;
	localparam int MID_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;
	localparam int TGT_W = (N_TARGETS > 1) ? $clog2(N_TARGETS) : 1;

	// Target indices, decode-fail target is last
	localparam logic [TGT_W-1:0] TGT_SRAM = 1'd0;
	localparam logic [TGT_W-1:0] TGT_ERR = 1'd1;

	// Master to target
	typedef struct packed {
		logic [WB_ADDR_W-1:0] adr;
		logic [WB_DATA_W-1:0] dat_w;
		logic [WB_SEL_W-1:0]  sel;
		logic                 we;
		logic                 cyc;
		logic                 stb;
	} wb_req_t;

	// Target to master
	typedef struct packed {
		logic [WB_DATA_W-1:0] dat_r;
		logic                 ack;
		logic                 err;
	} wb_rsp_t;

endpackage

/* src/wb_rr_arbiter.sv */
`timescale 1ns/1ns

module wb_rr_arbiter
	import wb_pkg::*;
(
	input  logic                 clk,
	input  logic                 rstn,
	input  logic [N_MASTERS-1:0] req_i,
	output logic                 gnt_o,
	output logic [MID_W-1:0]     gnt_id_o
);

	logic                 busy;
	logic [N_MASTERS-1:0] gnt_vec;
	logic [N_MASTERS-1:0] last_gnt;
	logic [MID_W-1:0]     gnt_id;
	logic [N_MASTERS-1:0] after_last;
	logic [N_MASTERS-1:0] masked_req;
	logic [N_MASTERS-1:0] masked_gnt;
	logic [N_MASTERS-1:0] unmasked_gnt;
	logic [N_MASTERS-1:0] win;

	function automatic logic [MID_W-1:0] onehot_to_id(input logic [N_MASTERS-1:0] v);
		logic [MID_W-1:0] id;
		id = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (v[i]) begin
				id = id | MID_W'(i);
			end
		end
		return id;
	endfunction

	// Indices strictly above the last granted master
	assign after_last = ~(last_gnt | (last_gnt - 1'b1));
	assign masked_req = req_i & after_last;

	// Lowest set bit, in one-hot form
	assign masked_gnt = masked_req & (~masked_req + 1'b1);
	assign unmasked_gnt = req_i & (~req_i + 1'b1);

	// Wrap to the lowest index when nobody follows the last grant
	assign win = (|masked_gnt) ? masked_gnt : unmasked_gnt;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			busy <= 1'b0;
			gnt_vec <= '0;
			last_gnt <= '0;
			gnt_id <= '0;
		end else if (!busy) begin
			if (|win) begin
				busy <= 1'b1;
				gnt_vec <= win;
				last_gnt <= win;
				gnt_id <= onehot_to_id(win);
			end
		end else if ((gnt_vec & req_i) == '0) begin
			// Owner released its request
			busy <= 1'b0;
			gnt_vec <= '0;
		end
	end

	assign gnt_o = busy;
	assign gnt_id_o = gnt_id;

	// A grant is neither given nor kept past a cycle without any request
	a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rstn)
		gnt_o |-> $past(|req_i));

endmodule

/* src/wb_sram_slave.sv */
`timescale 1ns/1ns

module wb_sram_slave
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [WB_DATA_W-1:0]  mem [SRAM_DEPTH];
	logic [SRAM_IDX_W-1:0] idx;
	logic                  hit;
	logic                  ack_q;
	logic [WB_DATA_W-1:0]  dat_q;

	// Word index from the byte address
	assign idx = req_i.adr[SRAM_IDX_W+1:2];

	// Answer once per transfer, the master holds stb until it sees ack
	assign hit = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (hit) begin
			if (req_i.we) begin
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (req_i.sel[b]) begin
						mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
					end
				end
			end
			dat_q <= mem[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	always_comb begin
		rsp_o.dat_r = dat_q;
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
		ack_q |=> !ack_q);

endmodule

/* src/wb_subsys_top.sv */
`timescale 1ns/1ns

module wb_subsys_top
	import wb_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  wb_req_t m0_req_i,
	output wb_rsp_t m0_rsp_o,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m1_rsp_o
);

	// Link between the interconnect and the memory
	wb_req_t sram_req;
	wb_rsp_t sram_rsp;

	wb_interconnect_2x1 interconnect_inst (
		.clk        (clk),
		.rstn       (rstn),
		.m0_req_i   (m0_req_i),
		.m0_rsp_o   (m0_rsp_o),
		.m1_req_i   (m1_req_i),
		.m1_rsp_o   (m1_rsp_o),
		.sram_req_o (sram_req),
		.sram_rsp_i (sram_rsp)
	);

	// 1 KiB memory target
	wb_sram_slave sram_inst (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (sram_req),
		.rsp_o (sram_rsp)
	);

endmodule
